/* hdl/fx1_lane.sv */
`timescale 1ns/1ps

module fx1_lane
    import spu_params_pkg::*;
    import spu_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  lane_cmd_t         cmd,
    output logic [word_w-1:0] result
);

    logic                  sub_path;
    logic [word_w-1:0]     x_word;
    logic [halfword_w:0]   sum_lo;
    logic [halfword_w:0]   sum_hi;
    logic                  carry_mid;
    logic [word_w-1:0]     sum_word;
    logic [halfword_w-1:0] a_hi, a_lo, b_hi, b_lo;
    logic                  eq_hi, eq_lo, gtu_hi, gtu_lo, gts_hi, gts_lo;
    logic                  cmp_hi, cmp_lo, cmp_word;
    logic [word_w-1:0]     cmp_res;
    logic [word_w-1:0]     next_result;

    // b - a is formed as b + ~a + 1
    assign sub_path = (cmd.op == lane_sub_from) || (cmd.op == lane_borrow_gen);
    assign x_word   = sub_path ? ~cmd.a : cmd.a;

    // Two halfword adders, chained only in word mode
    assign sum_lo    = {1'b0, x_word[halfword_w-1:0]} + {1'b0, cmd.b[halfword_w-1:0]}
                     + {{halfword_w{1'b0}}, sub_path};
    assign carry_mid = cmd.hw ? sub_path : sum_lo[halfword_w];
    assign sum_hi    = {1'b0, x_word[word_w-1:halfword_w]} + {1'b0, cmd.b[word_w-1:halfword_w]}
                     + {{halfword_w{1'b0}}, carry_mid};
    assign sum_word  = {sum_hi[halfword_w-1:0], sum_lo[halfword_w-1:0]};

    assign a_hi = cmd.a[word_w-1:halfword_w];
    assign a_lo = cmd.a[halfword_w-1:0];
    assign b_hi = cmd.b[word_w-1:halfword_w];
    assign b_lo = cmd.b[halfword_w-1:0];

    assign eq_hi  = (a_hi == b_hi);
    assign eq_lo  = (a_lo == b_lo);
    assign gtu_hi = (a_hi > b_hi);
    assign gtu_lo = (a_lo > b_lo);
    assign gts_hi = ($signed(a_hi) > $signed(b_hi));
    assign gts_lo = ($signed(a_lo) > $signed(b_lo));

    always_comb begin
        case (cmd.op)
            lane_cmp_eq: begin
                cmp_hi   = eq_hi;
                cmp_lo   = eq_lo;
                cmp_word = eq_hi & eq_lo;
            end
            lane_cmp_gt: begin
                cmp_hi   = gts_hi;
                cmp_lo   = gts_lo;
                // Low half of a word compares unsigned
                cmp_word = gts_hi | (eq_hi & gtu_lo);
            end
            default: begin
                cmp_hi   = gtu_hi;
                cmp_lo   = gtu_lo;
                cmp_word = gtu_hi | (eq_hi & gtu_lo);
            end
        endcase
    end

    assign cmp_res = cmd.hw ? {{(halfword_w-1){1'b0}}, cmp_hi, {(halfword_w-1){1'b0}}, cmp_lo}
                            : {{(word_w-1){1'b0}}, cmp_word};

    always_comb begin
        case (cmd.op)
            lane_add, lane_sub_from: next_result = sum_word;
            lane_carry_gen:          next_result = {{(word_w-1){1'b0}}, sum_hi[halfword_w]};
            // Carry out of b + ~a + 1 means b >= a
            lane_borrow_gen:         next_result = {{(word_w-1){1'b0}}, sum_hi[halfword_w]};
            lane_and:                next_result = cmd.a & cmd.b;
            lane_andc:               next_result = cmd.a & ~cmd.b;
            lane_or:                 next_result = cmd.a | cmd.b;
            lane_orc:                next_result = cmd.a | ~cmd.b;
            lane_xor:                next_result = cmd.a ^ cmd.b;
            lane_nand:               next_result = ~(cmd.a & cmd.b);
            lane_nor:                next_result = ~(cmd.a | cmd.b);
            default:                 next_result = cmp_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= next_result;
        end
    end

endmodule

/* hdl/fx1_operand_stage.sv */
`timescale 1ns/1ps

module fx1_operand_stage
    import spu_params_pkg::*;
    import spu_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fx1_issue_t issue,
    output lane_cmd_t  lane_cmd [num_lanes],
    output wb_ctrl_t   wb_ctrl
);

    lane_op_e                dec_op;
    logic                    dec_hw;
    logic                    dec_imm;
    logic                    dec_known;
    logic [halfword_w-1:0]   imm_half;
    logic [word_w-1:0]       imm_word;

    always_comb begin
        dec_op    = lane_add;
        dec_hw    = 1'b0;
        dec_imm   = 1'b0;
        dec_known = 1'b1;
        case (issue.opcode)
            op_add_word:      dec_op = lane_add;
            op_add_word_imm:  begin dec_op = lane_add;      dec_imm = 1'b1; end
            op_sf_word:       dec_op = lane_sub_from;
            op_sf_word_imm:   begin dec_op = lane_sub_from; dec_imm = 1'b1; end
            op_carry_gen:     dec_op = lane_carry_gen;
            op_borrow_gen:    dec_op = lane_borrow_gen;
            op_add_hw:        begin dec_op = lane_add;      dec_hw = 1'b1; end
            op_add_hw_imm:    begin dec_op = lane_add;      dec_hw = 1'b1; dec_imm = 1'b1; end
            op_sf_hw:         begin dec_op = lane_sub_from; dec_hw = 1'b1; end
            op_sf_hw_imm:     begin dec_op = lane_sub_from; dec_hw = 1'b1; dec_imm = 1'b1; end
            op_and:           dec_op = lane_and;
            op_andc:          dec_op = lane_andc;
            op_and_hw_imm:    begin dec_op = lane_and;      dec_hw = 1'b1; dec_imm = 1'b1; end
            op_and_word_imm:  begin dec_op = lane_and;      dec_imm = 1'b1; end
            op_or:            dec_op = lane_or;
            op_orc:           dec_op = lane_orc;
            op_or_hw_imm:     begin dec_op = lane_or;       dec_hw = 1'b1; dec_imm = 1'b1; end
            op_or_word_imm:   begin dec_op = lane_or;       dec_imm = 1'b1; end
            op_xor:           dec_op = lane_xor;
            op_xor_hw_imm:    begin dec_op = lane_xor;      dec_hw = 1'b1; dec_imm = 1'b1; end
            op_xor_word_imm:  begin dec_op = lane_xor;      dec_imm = 1'b1; end
            op_nand:          dec_op = lane_nand;
            op_nor:           dec_op = lane_nor;
            op_ceq_hw:        begin dec_op = lane_cmp_eq;   dec_hw = 1'b1; end
            op_ceq_hw_imm:    begin dec_op = lane_cmp_eq;   dec_hw = 1'b1; dec_imm = 1'b1; end
            op_ceq_word:      dec_op = lane_cmp_eq;
            op_ceq_word_imm:  begin dec_op = lane_cmp_eq;   dec_imm = 1'b1; end
            op_cgt_hw:        begin dec_op = lane_cmp_gt;   dec_hw = 1'b1; end
            op_cgt_hw_imm:    begin dec_op = lane_cmp_gt;   dec_hw = 1'b1; dec_imm = 1'b1; end
            op_cgt_word:      dec_op = lane_cmp_gt;
            op_cgt_word_imm:  begin dec_op = lane_cmp_gt;   dec_imm = 1'b1; end
            op_clgt_hw:       begin dec_op = lane_cmp_lgt;  dec_hw = 1'b1; end
            op_clgt_hw_imm:   begin dec_op = lane_cmp_lgt;  dec_hw = 1'b1; dec_imm = 1'b1; end
            op_clgt_word:     dec_op = lane_cmp_lgt;
            op_clgt_word_imm: begin dec_op = lane_cmp_lgt;  dec_imm = 1'b1; end
            // Belongs to another unit
            default:          dec_known = 1'b0;
        endcase
    end

    // Halfword forms replicate the immediate into both halves of a word
    assign imm_half = {{(halfword_w - imm10_w){issue.imm10[imm10_w-1]}}, issue.imm10};
    assign imm_word = dec_hw ? {imm_half, imm_half}
                             : {{(word_w - imm10_w){issue.imm10[imm10_w-1]}}, issue.imm10};

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_lanes; i++) begin
            if (!rst_n) begin
                lane_cmd[i].valid <= 1'b0;
            end else begin
                lane_cmd[i].valid <= issue.valid && dec_known;
            end
            lane_cmd[i].op <= dec_op;
            lane_cmd[i].hw <= dec_hw;
            // Lane 0 takes the most significant word
            lane_cmd[i].a  <= issue.ra[quadword_w - 1 - i * word_w -: word_w];
            lane_cmd[i].b  <= dec_imm ? imm_word
                                      : issue.rb[quadword_w - 1 - i * word_w -: word_w];
        end
        if (!rst_n) begin
            wb_ctrl.valid <= 1'b0;
        end else begin
            wb_ctrl.valid <= issue.valid && dec_known;
        end
        wb_ctrl.rt_addr <= issue.rt_addr;
    end

endmodule

/* hdl/fx1_unit.sv */
`timescale 1ns/1ps

module fx1_unit
    import spu_params_pkg::*;
    import spu_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fx1_issue_t issue,
    output fx1_wb_t    wb
);

    lane_cmd_t         lane_cmd [num_lanes];
    wb_ctrl_t          wb_ctrl;
    logic [word_w-1:0] lane_result [num_lanes];

    fx1_operand_stage u_operand_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .lane_cmd (lane_cmd),
        .wb_ctrl  (wb_ctrl)
    );

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        fx1_lane u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .cmd    (lane_cmd[g]),
            .result (lane_result[g])
        );
    end

    fx1_writeback_stage u_writeback_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (wb_ctrl),
        .lane_result (lane_result),
        .wb          (wb)
    );

endmodule

/* hdl/fx1_writeback_stage.sv */
`timescale 1ns/1ps

module fx1_writeback_stage
    import spu_params_pkg::*;
    import spu_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  wb_ctrl_t          ctrl,
    input  logic [word_w-1:0] lane_result [num_lanes],
    output fx1_wb_t           wb
);

    wb_ctrl_t                ctrl_q;
    logic [quadword_w-1:0]   rt_word;

    // Lane 0 lands in the preferred slot
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            rt_word[quadword_w - 1 - i * word_w -: word_w] = lane_result[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q.valid <= 1'b0;
            wb.wr_en     <= 1'b0;
        end else begin
            ctrl_q.valid <= ctrl.valid;
            wb.wr_en     <= ctrl_q.valid;
        end
        ctrl_q.rt_addr <= ctrl.rt_addr;
        wb.rt_addr     <= ctrl_q.rt_addr;
        wb.rt          <= rt_word;
    end

endmodule

/* hdl/spu_isa_pkg.sv */
package spu_isa_pkg;
    import spu_params_pkg::*;

    // Internal opcodes handled by the first simple fixed-point unit
    typedef enum logic [opcode_w-1:0] {
        op_add_word         = 7'd1,
        op_add_word_imm     = 7'd2,
        op_sf_word          = 7'd3,
        op_sf_word_imm      = 7'd4,
        op_carry_gen        = 7'd6,
        op_borrow_gen       = 7'd8,
        op_add_hw           = 7'd9,
        op_add_hw_imm       = 7'd10,
        op_sf_hw            = 7'd11,
        op_sf_hw_imm        = 7'd12,
        op_and              = 7'd16,
        op_andc             = 7'd17,
        op_and_hw_imm       = 7'd18,
        op_and_word_imm     = 7'd19,
        op_or               = 7'd20,
        op_orc              = 7'd21,
        op_or_hw_imm        = 7'd22,
        op_or_word_imm      = 7'd23,
        op_xor              = 7'd24,
        op_xor_hw_imm       = 7'd25,
        op_xor_word_imm     = 7'd26,
        op_nand             = 7'd27,
        op_nor              = 7'd28,
        op_ceq_hw           = 7'd29,
        op_ceq_hw_imm       = 7'd30,
        op_ceq_word         = 7'd31,
        op_ceq_word_imm     = 7'd32,
        op_cgt_hw           = 7'd33,
        op_cgt_hw_imm       = 7'd34,
        op_cgt_word         = 7'd35,
        op_cgt_word_imm     = 7'd36,
        op_clgt_hw          = 7'd37,
        op_clgt_hw_imm      = 7'd38,
        op_clgt_word        = 7'd39,
        op_clgt_word_imm    = 7'd40
    } fx1_opcode_e;

    // What a lane does, whatever the operand form
    typedef enum logic [3:0] {
        lane_add,
        lane_sub_from,
        lane_carry_gen,
        lane_borrow_gen,
        lane_and,
        lane_andc,
        lane_or,
        lane_orc,
        lane_xor,
        lane_nand,
        lane_nor,
        lane_cmp_eq,
        lane_cmp_gt,
        lane_cmp_lgt
    } lane_op_e;

    typedef struct packed {
        logic                    valid;
        fx1_opcode_e             opcode;
        logic [reg_addr_w-1:0]   rt_addr;
        logic [quadword_w-1:0]   ra;
        logic [quadword_w-1:0]   rb;
        logic [imm10_w-1:0]      imm10;
    } fx1_issue_t;

    typedef struct packed {
        logic                valid;
        lane_op_e            op;
        logic                hw;
        logic [word_w-1:0]   a;
        logic [word_w-1:0]   b;
    } lane_cmd_t;

    typedef struct packed {
        logic                    valid;
        logic [reg_addr_w-1:0]   rt_addr;
    } wb_ctrl_t;

    typedef struct packed {
        logic                    wr_en;
        logic [reg_addr_w-1:0]   rt_addr;
        logic [quadword_w-1:0]   rt;
    } fx1_wb_t;

endpackage

/* hdl/spu_params_pkg.sv */
package spu_params_pkg;

    // Register file and datapath widths
    localparam int quadword_w = 128;
    localparam int word_w     = 32;
    localparam int halfword_w = 16;

    // Word lanes across one quadword
    localparam int num_lanes = 4;

    // Instruction fields
    localparam int opcode_w   = 7;
    localparam int reg_addr_w = 7;
    localparam int imm10_w    = 10;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fx1 unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module fx1_unit_tb -Mdir obj_dir

# The log decides the result, so a stopped run must not end the script here
./obj_dir/Vfx1_unit_tb | tee sim.log

if grep -q "Testbench passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi

/* sources.f */
+incdir+include
hdl/spu_params_pkg.sv
hdl/spu_isa_pkg.sv
hdl/fx1_operand_stage.sv
hdl/fx1_lane.sv
hdl/fx1_writeback_stage.sv
hdl/fx1_unit.sv
testbench/fx1_unit_tb.sv

/* include/fx1_tb_tasks.svh */
`ifndef FX1_TB_TASKS_SVH
`define FX1_TB_TASKS_SVH

// Equal operands matter for borrow generate
task automatic word_arith_test();
    logic [6:0]   ops [6];
    logic [127:0] q;
    ops = '{op_add_word, op_add_word_imm, op_sf_word, op_sf_word_imm, op_carry_gen,
            op_borrow_gen};
    foreach (ops[k]) begin
        q = rand_quad();
        send(ops[k], q, q, rand_imm());
        send(ops[k], {4{32'hffff_ffff}}, {4{32'hffff_ffff}}, 10'h3ff);
        send(ops[k], {4{32'h8000_0000}}, {4{32'h8000_0000}}, 10'h200);
        send(ops[k], {2{64'h8000_0000_0000_0001}}, {2{64'hffff_ffff_7fff_ffff}}, 10'h3fe);
        repeat (4) send(ops[k], rand_quad(), rand_quad(), rand_imm());
    end
    send_slot(1'b0, op_add_word, '0, '0, '0);
endtask

// Low halfword carries and borrows would spill into the upper one
task automatic halfword_arith_test();
    logic [6:0] ops [4];
    ops = '{op_add_hw, op_add_hw_imm, op_sf_hw, op_sf_hw_imm};
    foreach (ops[k]) begin
        send(ops[k], {4{32'h7fff_ffff}}, {4{32'h0001_0001}}, 10'h001);
        send(ops[k], {4{32'h0000_0002}}, {4{32'h0005_0001}}, 10'h3ff);
        send(ops[k], {2{64'hffff_0000_8000_ffff}}, {2{64'h0001_0001_8000_0001}}, 10'h200);
        repeat (3) send(ops[k], rand_quad(), rand_quad(), rand_imm());
    end
    send_slot(1'b0, op_add_word, '0, '0, '0);
endtask

task automatic logic_test();
    logic [6:0] ops [13];
    ops = '{op_and, op_andc, op_or, op_orc, op_xor, op_nand, op_nor, op_and_hw_imm,
            op_and_word_imm, op_or_hw_imm, op_or_word_imm, op_xor_hw_imm, op_xor_word_imm};
    foreach (ops[k]) begin
        repeat (4) send(ops[k], rand_quad(), rand_quad(), rand_imm());
    end
    send_slot(1'b0, op_add_word, '0, '0, '0);
endtask

task automatic compare_test();
    logic [6:0]   ops [12];
    logic [127:0] q;
    ops = '{op_ceq_hw, op_ceq_hw_imm, op_ceq_word, op_ceq_word_imm, op_cgt_hw, op_cgt_hw_imm,
            op_cgt_word, op_cgt_word_imm, op_clgt_hw, op_clgt_hw_imm, op_clgt_word,
            op_clgt_word_imm};
    foreach (ops[k]) begin
        q = rand_quad();
        send(ops[k], q, q, rand_imm());
        // Signed and unsigned order differ across 0x8000
        send(ops[k], {4{32'h8000_7fff}}, {4{32'h7fff_8000}}, 10'h200);
        send(ops[k], {4{32'h1234_8000}}, {4{32'h1234_7fff}}, 10'h1ff);
        send(ops[k], {2{64'h01ff_01ff_0000_01ff}}, {2{64'hfe00_0200_ffff_fe00}}, 10'h1ff);
        repeat (3) send(ops[k], rand_quad(), rand_quad(), rand_imm());
    end
    send_slot(1'b0, op_add_word, '0, '0, '0);
endtask

// Foreign opcodes and valid-low slots mixed into a back-to-back stream
task automatic stream_test();
    logic [6:0] op;
    for (int k = 0; k < 32; k++) begin
        do begin
            op = 7'($random(seed));
        end while (!is_kept(op));
        case (k % 8)
            2:       send(7'd13, rand_quad(), rand_quad(), rand_imm());
            4:       send_slot(1'b0, op, rand_quad(), rand_quad(), rand_imm());
            5:       send(7'd49, rand_quad(), rand_quad(), rand_imm());
            7:       send(7'd61, rand_quad(), rand_quad(), rand_imm());
            default: send(op, rand_quad(), rand_quad(), rand_imm());
        endcase
    end
    send_slot(1'b0, op_add_word, '0, '0, '0);
endtask

`endif

/* testbench/fx1_unit_tb.sv */
`timescale 1ns/1ps

module fx1_unit_tb
    import spu_params_pkg::*;
    import spu_isa_pkg::*;
();

    localparam int clk_period   = 100;
    localparam int reset_cycles = 16;
    // Issue slots of all directed tests together
    localparam int test_slots   = 245;

    typedef struct packed {
        int                      due;
        logic [reg_addr_w-1:0]   rt_addr;
        logic [quadword_w-1:0]   rt;
    } expect_t;

    bit         clk;
    logic       rst_n;
    fx1_issue_t issue;
    fx1_wb_t    wb;
    int         seed;
    int         cycle_n;
    int         slot_count;
    int         rd_idx;
    expect_t    exp_q [$];

    fx1_unit UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .wb    (wb)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_n <= cycle_n + 1;
    end

    function automatic logic is_kept(input logic [6:0] op);
        return op inside {[7'd1:7'd4], 7'd6, [7'd8:7'd12], [7'd16:7'd40]};
    endfunction

    // Halfwords arrive sign-extended, which keeps their unsigned order
    function automatic logic [31:0] elem_result(input logic [6:0] op, input logic [31:0] a,
                                                input logic [31:0] b, input logic [31:0] imm);
        logic [32:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        case (op)
            op_add_word, op_add_hw:           return a + b;
            op_add_word_imm, op_add_hw_imm:   return a + imm;
            op_sf_word, op_sf_hw:             return b - a;
            op_sf_word_imm, op_sf_hw_imm:     return imm - a;
            op_carry_gen:                     return {31'b0, sum[32]};
            op_borrow_gen:                    return {31'b0, b >= a};
            op_and:                           return a & b;
            op_andc:                          return a & ~b;
            op_and_hw_imm, op_and_word_imm:   return a & imm;
            op_or:                            return a | b;
            op_orc:                           return a | ~b;
            op_or_hw_imm, op_or_word_imm:     return a | imm;
            op_xor:                           return a ^ b;
            op_xor_hw_imm, op_xor_word_imm:   return a ^ imm;
            op_nand:                          return ~(a & b);
            op_nor:                           return ~(a | b);
            op_ceq_hw, op_ceq_word:           return {31'b0, a == b};
            op_ceq_hw_imm, op_ceq_word_imm:   return {31'b0, a == imm};
            op_cgt_hw, op_cgt_word:           return {31'b0, $signed(a) > $signed(b)};
            op_cgt_hw_imm, op_cgt_word_imm:   return {31'b0, $signed(a) > $signed(imm)};
            op_clgt_hw, op_clgt_word:         return {31'b0, a > b};
            op_clgt_hw_imm, op_clgt_word_imm: return {31'b0, a > imm};
            default:                          return 32'h0;
        endcase
    endfunction

    function automatic logic [127:0] expected_rt(input logic [6:0] op, input logic [127:0] ra,
                                                 input logic [127:0] rb, input logic [9:0] imm);
        logic [31:0]  imm_w, a, b, hi, lo;
        logic [127:0] q;
        logic         hw;
        imm_w = {{22{imm[9]}}, imm};
        hw    = op inside {op_add_hw, op_add_hw_imm, op_sf_hw, op_sf_hw_imm, op_and_hw_imm,
                           op_or_hw_imm, op_xor_hw_imm, op_ceq_hw, op_ceq_hw_imm, op_cgt_hw,
                           op_cgt_hw_imm, op_clgt_hw, op_clgt_hw_imm};
        // Word 0 is the most significant one
        for (int i = 0; i < 4; i++) begin
            a = ra[127 - 32 * i -: 32];
            b = rb[127 - 32 * i -: 32];
            hi = elem_result(op, {{16{a[31]}}, a[31:16]}, {{16{b[31]}}, b[31:16]}, imm_w);
            lo = elem_result(op, {{16{a[15]}}, a[15:0]}, {{16{b[15]}}, b[15:0]}, imm_w);
            q[127 - 32 * i -: 32] = hw ? {hi[15:0], lo[15:0]} : elem_result(op, a, b, imm_w);
        end
        return q;
    endfunction

    function automatic logic [127:0] rand_quad();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic logic [9:0] rand_imm();
        return 10'($random(seed));
    endfunction

    task automatic stop_on_failure();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // One issue slot; a kept valid opcode expects its record three edges later
    task automatic send_slot(input logic valid, input logic [6:0] op, input logic [127:0] ra,
                             input logic [127:0] rb, input logic [9:0] imm);
        expect_t e;
        @(posedge clk);
        #1;
        issue.valid   = valid;
        issue.opcode  = fx1_opcode_e'(op);
        issue.rt_addr = slot_count[6:0];
        issue.ra      = ra;
        issue.rb      = rb;
        issue.imm10   = imm;
        if (valid && is_kept(op)) begin
            e.due     = cycle_n + 3;
            e.rt_addr = slot_count[6:0];
            e.rt      = expected_rt(op, ra, rb, imm);
            exp_q.push_back(e);
        end
        slot_count++;
    endtask

    task automatic send(input logic [6:0] op, input logic [127:0] ra, input logic [127:0] rb,
                        input logic [9:0] imm);
        send_slot(1'b1, op, ra, rb, imm);
    endtask

    // wb is stable at the falling edge
    always @(negedge clk) begin
        if (rd_idx < exp_q.size() && exp_q[rd_idx].due == cycle_n) begin
            check_value("wb.wr_en", 128'h1, {127'b0, wb.wr_en});
            check_value("wb.rt_addr", {121'b0, exp_q[rd_idx].rt_addr}, {121'b0, wb.rt_addr});
            check_value("wb.rt", exp_q[rd_idx].rt, wb.rt);
            rd_idx = rd_idx + 1;
        end else begin
            check_value("wb.wr_en", 128'h0, {127'b0, wb.wr_en});
        end
    end

    initial begin
        #((test_slots + reset_cycles + 50) * clk_period);
        $display("Timeout: the tests did not finish within the time limit");
        stop_on_failure();
    end

    `include "fx1_tb_tasks.svh"

    initial begin
        seed  = 32'h7ba8;
        rst_n = 1'b0;
        issue = '0;
        // A valid issue under reset must not write
        issue.valid  = 1'b1;
        issue.opcode = op_add_word;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n       = 1'b1;
        issue.valid = 1'b0;
        word_arith_test();
        halfword_arith_test();
        logic_test();
        compare_test();
        stream_test();
        while (rd_idx < exp_q.size()) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule
